// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [3:0]      byte_en_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [4:0] {
        idle,
        fetch,
        fetch_wait,
        decode,
        reg_reg,
        lui,
        reg_imm,
        auipc,
        jal,
        branch,
        jalr,
        load,
        load_wait,
        store,
        store_wait,
        ecall_state
    } state_t;

    // base opcodes, low two bits always 11
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_type_t;

    // one instruction word seen through each encoding format
    typedef union packed {
        word_t   raw;
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

    typedef struct packed {
        logic       alua_src;
        logic       alub_src;
        logic [2:0] alu_op;
        logic       sub;
        logic       arithmetic;
        logic       alupc_src;
        logic       pc_src;
        logic       pc_en;
        logic [1:0] wr_reg_src;
        logic       wr_reg_en;
        logic       ir_en;
        logic       mem_addr_src;
    } ctrl_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } flags_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } decode_t;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t  a,
    input  rv_pkg::word_t  b,
    input  logic [2:0]     alu_op,
    input  logic           sub,
    input  logic           arithmetic,
    output rv_pkg::word_t  result,
    output rv_pkg::flags_t flags
);

    rv_pkg::word_t         b_eff;
    logic [rv_pkg::xlen:0] sum;
    logic [4:0]            shamt;
    logic                  less_signed;
    logic                  less_unsigned;

    // subtraction as a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {{rv_pkg::xlen{1'b0}}, sub};
    assign shamt = b[4:0];

    assign less_signed   = $signed(a) < $signed(b);
    assign less_unsigned = a < b;

    assign flags.zero     = (sum[rv_pkg::xlen-1:0] == '0);
    assign flags.negative = sum[rv_pkg::xlen-1];
    assign flags.carry    = sum[rv_pkg::xlen];
    assign flags.overflow = (a[rv_pkg::xlen-1] == b_eff[rv_pkg::xlen-1])
                          && (sum[rv_pkg::xlen-1] != a[rv_pkg::xlen-1]);

    always_comb begin
        case (alu_op)
            3'b000: result = sum[rv_pkg::xlen-1:0];
            3'b001: result = a << shamt;
            3'b010: result = {{(rv_pkg::xlen-1){1'b0}}, less_signed};
            3'b011: result = {{(rv_pkg::xlen-1){1'b0}}, less_unsigned};
            3'b100: result = a ^ b;
            3'b101: result = arithmetic ? rv_pkg::word_t'($signed(a) >>> shamt) : a >> shamt;
            3'b110: result = a | b;
            default: result = a & b;
        endcase
    end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              wr_en,
    input  rv_pkg::word_t     wr_data,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             mem_busy,
    input  rv_pkg::decode_t  decode,
    input  rv_pkg::flags_t   flags,
    output rv_pkg::ctrl_t    ctrl,
    output logic             mem_rd_en,
    output logic             mem_wr_en,
    output rv_pkg::byte_en_t mem_byte_en,
    output logic             ecall,
    output logic             illegal_instruction
);

    rv_pkg::state_t   state;
    rv_pkg::state_t   next_state;
    logic             beq_bne;
    logic             blt_bge;
    logic             bltu_bgeu;
    logic             taken;
    rv_pkg::byte_en_t byte_en;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= rv_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // branch decision from the rs1 - rs2 flags
    assign beq_bne   = flags.zero ^ decode.funct3[0];
    assign blt_bge   = (flags.negative ^ flags.overflow) ^ decode.funct3[0];
    assign bltu_bgeu = flags.carry ~^ decode.funct3[0];
    assign taken     = decode.funct3[1] ? bltu_bgeu
                                        : (decode.funct3[2] ? blt_bge : beq_bne);

    // byte, half or word lanes
    assign byte_en = decode.funct3[1] ? 4'hF : (decode.funct3[0] ? 4'h3 : 4'h1);

    always_comb begin
        ctrl                = '0;
        mem_rd_en           = 1'b0;
        mem_wr_en           = 1'b0;
        mem_byte_en         = '0;
        ecall               = 1'b0;
        illegal_instruction = 1'b0;
        next_state          = rv_pkg::fetch;

        case (state)
            rv_pkg::idle: begin
                next_state = rv_pkg::fetch;
            end

            rv_pkg::fetch: begin
                mem_rd_en   = 1'b1;
                mem_byte_en = 4'hF;
                next_state  = mem_busy ? rv_pkg::fetch_wait : rv_pkg::fetch;
            end

            rv_pkg::fetch_wait: begin
                mem_byte_en = 4'hF;
                if (mem_busy) begin
                    mem_rd_en  = 1'b1;
                    next_state = rv_pkg::fetch_wait;
                end else begin
                    ctrl.ir_en = 1'b1;
                    next_state = rv_pkg::decode;
                end
            end

            rv_pkg::decode: begin
                if (decode.opcode[1:0] != 2'b11) begin
                    illegal_instruction = 1'b1;
                end else begin
                    case (decode.opcode)
                        rv_pkg::op_reg:    next_state = rv_pkg::reg_reg;
                        rv_pkg::op_imm:    next_state = rv_pkg::reg_imm;
                        rv_pkg::op_lui:    next_state = rv_pkg::lui;
                        rv_pkg::op_auipc:  next_state = rv_pkg::auipc;
                        rv_pkg::op_jal:    next_state = rv_pkg::jal;
                        rv_pkg::op_jalr:   next_state = rv_pkg::jalr;
                        rv_pkg::op_branch: next_state = rv_pkg::branch;
                        rv_pkg::op_load:   next_state = rv_pkg::load;
                        rv_pkg::op_store:  next_state = rv_pkg::store;
                        rv_pkg::op_system: begin
                            // only ECALL is supported here
                            if (decode.funct3 == 3'b000 && decode.funct7 == 7'b0) begin
                                next_state = rv_pkg::ecall_state;
                            end else begin
                                illegal_instruction = 1'b1;
                            end
                        end
                        default: illegal_instruction = 1'b1;
                    endcase
                end
            end

            rv_pkg::reg_reg: begin
                ctrl.alu_op     = decode.funct3;
                ctrl.sub        = decode.funct7[5];
                ctrl.arithmetic = decode.funct7[5];
                ctrl.pc_en      = 1'b1;
                ctrl.wr_reg_en  = 1'b1;
            end

            rv_pkg::reg_imm: begin
                ctrl.alub_src   = 1'b1;
                ctrl.alu_op     = decode.funct3;
                // srai shares funct3 with srli, the upper immediate bits pick it
                ctrl.arithmetic = decode.funct7[5] & (decode.funct3 == 3'b101);
                ctrl.pc_en      = 1'b1;
                ctrl.wr_reg_en  = 1'b1;
            end

            rv_pkg::lui: begin
                ctrl.alub_src  = 1'b1;
                ctrl.pc_en     = 1'b1;
                ctrl.wr_reg_en = 1'b1;
            end

            rv_pkg::auipc: begin
                ctrl.alua_src  = 1'b1;
                ctrl.alub_src  = 1'b1;
                ctrl.pc_en     = 1'b1;
                ctrl.wr_reg_en = 1'b1;
            end

            rv_pkg::jal: begin
                ctrl.pc_src     = 1'b1;
                ctrl.pc_en      = 1'b1;
                ctrl.wr_reg_src = 2'b11;
                ctrl.wr_reg_en  = 1'b1;
            end

            rv_pkg::jalr: begin
                ctrl.alub_src   = 1'b1;
                ctrl.alupc_src  = 1'b1;
                ctrl.pc_src     = 1'b1;
                ctrl.pc_en      = 1'b1;
                ctrl.wr_reg_src = 2'b11;
                ctrl.wr_reg_en  = 1'b1;
            end

            rv_pkg::branch: begin
                ctrl.sub    = 1'b1;
                ctrl.pc_src = taken;
                ctrl.pc_en  = 1'b1;
            end

            rv_pkg::load: begin
                ctrl.alub_src     = 1'b1;
                ctrl.mem_addr_src = 1'b1;
                ctrl.wr_reg_src   = 2'b10;
                mem_byte_en       = byte_en;
                mem_rd_en         = 1'b1;
                next_state        = mem_busy ? rv_pkg::load_wait : rv_pkg::load;
            end

            rv_pkg::load_wait: begin
                ctrl.alub_src     = 1'b1;
                ctrl.mem_addr_src = 1'b1;
                ctrl.wr_reg_src   = 2'b10;
                mem_byte_en       = byte_en;
                if (mem_busy) begin
                    mem_rd_en  = 1'b1;
                    next_state = rv_pkg::load_wait;
                end else begin
                    // data is valid on this cycle only
                    ctrl.wr_reg_en = 1'b1;
                    ctrl.pc_en     = 1'b1;
                end
            end

            rv_pkg::store: begin
                ctrl.alub_src     = 1'b1;
                ctrl.mem_addr_src = 1'b1;
                mem_byte_en       = byte_en;
                mem_wr_en         = 1'b1;
                next_state        = mem_busy ? rv_pkg::store_wait : rv_pkg::store;
            end

            rv_pkg::store_wait: begin
                ctrl.alub_src     = 1'b1;
                ctrl.mem_addr_src = 1'b1;
                mem_byte_en       = byte_en;
                if (mem_busy) begin
                    mem_wr_en  = 1'b1;
                    next_state = rv_pkg::store_wait;
                end else begin
                    ctrl.pc_en = 1'b1;
                end
            end

            rv_pkg::ecall_state: begin
                ecall = 1'b1;
            end

            default: next_state = rv_pkg::idle;
        endcase
    end

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic            clock,
    input  logic            reset,
    input  rv_pkg::ctrl_t   ctrl,
    output rv_pkg::decode_t decode,
    output rv_pkg::flags_t  flags,
    output rv_pkg::word_t   mem_addr,
    output rv_pkg::word_t   mem_wdata,
    input  rv_pkg::word_t   mem_rdata
);

    rv_pkg::word_t     pc;
    rv_pkg::word_t     pc_plus4;
    rv_pkg::word_t     pc_target;
    rv_pkg::instr_t    ir;
    rv_pkg::word_t     imm;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::word_t     rd1;
    rv_pkg::word_t     rd2;
    rv_pkg::word_t     alu_a;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     load_data;
    rv_pkg::word_t     wr_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_en) begin
            pc <= ctrl.pc_src ? pc_target : pc_plus4;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.ir_en) begin
            ir.raw <= mem_rdata;
        end
    end

    assign decode.opcode = ir.r.opcode;
    assign decode.funct3 = ir.r.funct3;
    assign decode.funct7 = ir.r.funct7;

    // immediate format follows the opcode
    always_comb begin
        case (ir.r.opcode)
            rv_pkg::op_lui, rv_pkg::op_auipc: imm = {ir.u.imm, 12'b0};
            rv_pkg::op_jal: imm = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12,
                                   ir.j.imm11, ir.j.imm10_1, 1'b0};
            rv_pkg::op_branch: imm = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11,
                                      ir.b.imm10_5, ir.b.imm4_1, 1'b0};
            rv_pkg::op_store: imm = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            default: imm = {{20{ir.i.imm[11]}}, ir.i.imm};
        endcase
    end

    // lui adds its immediate to x0
    assign rs1_addr = (ir.r.opcode == rv_pkg::op_lui) ? '0 : ir.r.rs1;

    register_file u_register_file (
        .clock   (clock),
        .reset   (reset),
        .rs1     (rs1_addr),
        .rs2     (ir.r.rs2),
        .rd      (ir.r.rd),
        .wr_en   (ctrl.wr_reg_en),
        .wr_data (wr_data),
        .rd1     (rd1),
        .rd2     (rd2)
    );

    assign alu_a = ctrl.alua_src ? pc : rd1;
    assign alu_b = ctrl.alub_src ? imm : rd2;

    alu u_alu (
        .a          (alu_a),
        .b          (alu_b),
        .alu_op     (ctrl.alu_op),
        .sub        (ctrl.sub),
        .arithmetic (ctrl.arithmetic),
        .result     (alu_result),
        .flags      (flags)
    );

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = ctrl.alupc_src ? {alu_result[rv_pkg::xlen-1:1], 1'b0} : pc + imm;

    // low lanes only, addresses are aligned
    always_comb begin
        case (ir.r.funct3)
            3'b000: load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            3'b001: load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            3'b100: load_data = {24'b0, mem_rdata[7:0]};
            3'b101: load_data = {16'b0, mem_rdata[15:0]};
            default: load_data = mem_rdata;
        endcase
    end

    always_comb begin
        case (ctrl.wr_reg_src)
            2'b10: wr_data = load_data;
            2'b11: wr_data = pc_plus4;
            default: wr_data = alu_result;
        endcase
    end

    assign mem_addr  = ctrl.mem_addr_src ? alu_result : pc;
    assign mem_wdata = rd2;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic             clock,
    input  logic             reset,
    input  logic             mem_busy,
    output logic             mem_rd_en,
    output logic             mem_wr_en,
    output rv_pkg::byte_en_t mem_byte_en,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    mem_wdata,
    input  rv_pkg::word_t    mem_rdata,
    output logic             ecall,
    output logic             illegal_instruction
);

    rv_pkg::ctrl_t   ctrl;
    rv_pkg::decode_t decode;
    rv_pkg::flags_t  flags;

    control_unit u_control_unit (
        .clock               (clock),
        .reset               (reset),
        .mem_busy            (mem_busy),
        .decode              (decode),
        .flags               (flags),
        .ctrl                (ctrl),
        .mem_rd_en           (mem_rd_en),
        .mem_wr_en           (mem_wr_en),
        .mem_byte_en         (mem_byte_en),
        .ecall               (ecall),
        .illegal_instruction (illegal_instruction)
    );

    datapath u_datapath (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .decode    (decode),
        .flags     (flags),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    typedef struct packed {
        rv_pkg::word_t    addr;
        rv_pkg::word_t    data;
        rv_pkg::byte_en_t byte_en;
    } store_row_t;

    localparam int prog_len   = 56;
    localparam int num_rows   = 23;
    localparam int cycle_limit = (prog_len + num_rows) * 16;
    localparam rv_pkg::word_t illegal_addr = 32'h0000_00dc;
    localparam rv_pkg::word_t ecall_word   = 32'h0000_0073;

    logic             clock;
    logic             reset;
    logic             mem_busy;
    logic             mem_rd_en;
    logic             mem_wr_en;
    rv_pkg::byte_en_t mem_byte_en;
    rv_pkg::word_t    mem_addr;
    rv_pkg::word_t    mem_wdata;
    rv_pkg::word_t    mem_rdata;
    logic             ecall;
    logic             illegal_instruction;

    rv_pkg::word_t mem [0:255];
    store_row_t    expected_stores [num_rows];
    int            row_index;
    int            cycles;
    int            seed;

    // alu block, loads, then branches and jumps; last word is illegal
    rv_pkg::word_t program_words [prog_len] = '{
        32'h00500093, 32'hffd00113, 32'h002081b3, 32'h40208233,
        32'h00409293, 32'h40115313, 32'h01c15393, 32'h00112433,
        32'h001134b3, 32'h0020c533, 32'h0020e5b3, 32'h0020f633,
        32'h123456b7, 32'h00001717, 32'h20000793, 32'h0037a023,
        32'h0047a023, 32'h0057a023, 32'h0067a023, 32'h0077a023,
        32'h0087a023, 32'h0097a023, 32'h00a7a023, 32'h00b7a023,
        32'h00c7a023, 32'h00d7a023, 32'h00e7a023, 32'h30000813,
        32'h00080883, 32'h00084903, 32'h00081983, 32'h00085a03,
        32'h00082a83, 32'h0117a023, 32'h0127a023, 32'h0137a023,
        32'h0147a023, 32'h0157a023, 32'h01578223, 32'h01579223,
        32'h5ad00b13, 32'h00108463, 32'h0167a023, 32'h00109463,
        32'h0017a023, 32'h00114463, 32'h0167a023, 32'h0020f463,
        32'h0027a023, 32'h00800bef, 32'h0167a023, 32'h0177a023,
        32'h010b8c67, 32'h0167a023, 32'h0187a023, 32'hdeadbeec
    };

    rv_core dut (
        .clock               (clock),
        .reset               (reset),
        .mem_busy            (mem_busy),
        .mem_rd_en           (mem_rd_en),
        .mem_wr_en           (mem_wr_en),
        .mem_byte_en         (mem_byte_en),
        .mem_addr            (mem_addr),
        .mem_wdata           (mem_wdata),
        .mem_rdata           (mem_rdata),
        .ecall               (ecall),
        .illegal_instruction (illegal_instruction)
    );

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_strobe(input string name, input rv_pkg::byte_en_t got,
                                input rv_pkg::byte_en_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "byte enable mismatch");
        end
    endtask

    task automatic check_pulse(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "pulse mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic add_row(input int idx, input rv_pkg::word_t addr,
                           input rv_pkg::word_t data, input rv_pkg::byte_en_t en);
        expected_stores[idx] = '{addr, data, en};
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset     = 1'b1;
        mem_busy  = 1'b0;
        mem_rdata = '0;
        row_index = 0;
        seed      = 32'h9cb8_faeb;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0]};
        end
        for (int i = 0; i < prog_len; i++) begin
            mem[i] = program_words[i];
        end
        mem[192] = 32'h8765_f0a4;
        add_row(0, 32'h200, 32'h0000_0002, 4'hF);
        add_row(1, 32'h200, 32'h0000_0008, 4'hF);
        add_row(2, 32'h200, 32'h0000_0050, 4'hF);
        add_row(3, 32'h200, 32'hffff_fffe, 4'hF);
        add_row(4, 32'h200, 32'h0000_000f, 4'hF);
        add_row(5, 32'h200, 32'h0000_0001, 4'hF);
        add_row(6, 32'h200, 32'h0000_0000, 4'hF);
        add_row(7, 32'h200, 32'hffff_fff8, 4'hF);
        add_row(8, 32'h200, 32'hffff_fffd, 4'hF);
        add_row(9, 32'h200, 32'h0000_0005, 4'hF);
        add_row(10, 32'h200, 32'h1234_5000, 4'hF);
        add_row(11, 32'h200, 32'h0000_1034, 4'hF);
        // sign and zero extended loads of 8765f0a4
        add_row(12, 32'h200, 32'hffff_ffa4, 4'hF);
        add_row(13, 32'h200, 32'h0000_00a4, 4'hF);
        add_row(14, 32'h200, 32'hffff_f0a4, 4'hF);
        add_row(15, 32'h200, 32'h0000_f0a4, 4'hF);
        add_row(16, 32'h200, 32'h8765_f0a4, 4'hF);
        add_row(17, 32'h204, 32'h8765_f0a4, 4'h1);
        add_row(18, 32'h204, 32'h8765_f0a4, 4'h3);
        add_row(19, 32'h200, 32'h0000_0005, 4'hF);
        add_row(20, 32'h200, 32'hffff_fffd, 4'hF);
        // link values of the jal and jalr
        add_row(21, 32'h200, 32'h0000_00c8, 4'hF);
        add_row(22, 32'h200, 32'h0000_00d4, 4'hF);
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clock);
            cycles++;
            if (cycles > cycle_limit) begin
                report_failure("timeout, the core did not reach the final ecall");
            end
        end
    end

    // memory model with busy rising one cycle after the strobe
    initial begin
        int   hold;
        logic is_write;
        forever begin
            @(negedge clock);
            if (!reset && (mem_rd_en || mem_wr_en)) begin
                is_write = mem_wr_en;
                hold     = 1 + ($unsigned($random(seed)) % 3);
                @(posedge clock);
                #1 mem_busy = 1'b1;
                repeat (hold) @(posedge clock);
                #1 mem_busy = 1'b0;
                mem_rdata = mem[mem_addr[9:2]];
                @(negedge clock);
                if (is_write) begin
                    if (row_index >= num_rows) begin
                        report_failure("more stores than expected");
                    end
                    check_word("mem_addr", mem_addr, expected_stores[row_index].addr);
                    check_word("mem_wdata", mem_wdata, expected_stores[row_index].data);
                    check_strobe("mem_byte_en", mem_byte_en,
                                 expected_stores[row_index].byte_en);
                    for (int b = 0; b < 4; b++) begin
                        if (mem_byte_en[b]) begin
                            mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                    row_index++;
                end
            end
        end
    end

    initial begin
        logic prev_reset;
        logic first_read;
        logic illegal_seen;
        logic refetch_check;
        logic ecall_seen;
        prev_reset    = 1'b1;
        first_read    = 1'b1;
        illegal_seen  = 1'b0;
        refetch_check = 1'b0;
        ecall_seen    = 1'b0;
        while (!ecall_seen) begin
            @(negedge clock);
            if (reset || prev_reset) begin
                check_pulse("mem_rd_en", mem_rd_en, 1'b0);
                check_pulse("mem_wr_en", mem_wr_en, 1'b0);
                check_pulse("ecall", ecall, 1'b0);
                check_pulse("illegal_instruction", illegal_instruction, 1'b0);
            end else begin
                if (first_read && mem_rd_en) begin
                    check_word("mem_addr", mem_addr, 32'h0);
                    check_strobe("mem_byte_en", mem_byte_en, 4'hF);
                    first_read = 1'b0;
                end
                if (refetch_check) begin
                    check_pulse("illegal_instruction", illegal_instruction, 1'b0);
                    check_pulse("mem_rd_en", mem_rd_en, 1'b1);
                    check_word("mem_addr", mem_addr, illegal_addr);
                    refetch_check = 1'b0;
                end
                if (illegal_instruction) begin
                    check_pulse("ecall", ecall, 1'b0);
                    illegal_seen  = 1'b1;
                    refetch_check = 1'b1;
                    mem[illegal_addr[9:2]] = ecall_word;
                end
                if (ecall) begin
                    check_pulse("illegal_instruction before ecall", illegal_seen, 1'b1);
                    ecall_seen = 1'b1;
                end
            end
            prev_reset = reset;
        end
        if (row_index == num_rows) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("only %0d of %0d stores seen", row_index, num_rows);
            $display("tests failed");
            $fatal(1, "missing stores");
        end
    end

endmodule

// ==== all.f ====
verilog/rv_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/datapath.sv
verilog/rv_core.sv
test/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_rv_core
FILELIST  ?= all.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
